/* project.f */
hdl/osd_pkg.sv
hdl/video_timing.sv
hdl/osd_window_layer.sv
hdl/pixel_dither_565.sv
hdl/osd_top.sv
tests/osd_tb.sv

/* run.sh */
#!/bin/sh
# build the OSD testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
  --top-module osd_tb -f project.f

output=$(./obj_dir/Vosd_tb)
echo "$output"

# pass only if the testbench printed its pass line
echo "$output" | grep -qx "Test completed successfully"

/* tests/osd_tb.sv */
// simulation top for osd_top that checks reset, background, windows, priority and a random enable frame
`timescale 1ns/1ns

module osd_tb
  import osd_pkg::*;
();

  localparam int H_ACTIVE = 32;
  localparam int H_FRONT  = 2;
  localparam int H_SYNC   = 3;
  localparam int H_BACK   = 3;
  localparam int V_ACTIVE = 16;
  localparam int V_FRONT  = 1;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 1;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int FRAME_TIMEOUT = 4000;

  localparam window_cfg_t WIN0 = '{x_start: 10'd4, x_stop: 10'd20, y_start: 10'd2,
                                   y_stop: 10'd10, border_color: 24'hff_ff_00,
                                   fill_color: 24'h20_80_f0};
  localparam window_cfg_t WIN1 = '{x_start: 10'd14, x_stop: 10'd28, y_start: 10'd6,
                                   y_stop: 10'd14, border_color: 24'hfa_00_fc,
                                   fill_color: 24'h00_fe_10};
  localparam window_cfg_t WIN_NONE = '0;

  logic        clk_pixel;
  logic        i_rst_n;
  logic        i_pixel_ena;
  rgb565_t     o_pix;
  logic        o_hsync;
  logic        o_vsync;
  logic        o_blank;

  logic [31:0] lcg_state = 32'h26d0_0177;
  logic        rand_ena = 1'b0;
  int          phase = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  int          err_reset = 0;
  int          err_bg = 0;
  int          err_l0 = 0;
  int          err_ovl = 0;
  int          err_frame = 0;
  int          err_count = 0;
  int          hit_bg = 0;
  int          hit_l0 = 0;
  int          hit_ovl = 0;
  int          hit_frame = 0;

  // model state counted on the output stream
  int          x_m;
  int          y_m;
  logic        hs_prev_m;
  logic        vs_prev_m;
  logic        line_act_m;
  logic        hs_rise;
  logic        vs_rise;
  int          hs_cnt;
  int          line_cnt;
  int          pix_cnt;
  int          frame_cnt;
  int          frame_hs = 0;
  int          frame_lines = 0;
  int          frame_pix = 0;
  int          pix_region;
  rgb565_t     exp_pix;

  osd_top #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK),
    .N_LAYERS (2),
    .WINDOWS  ({WIN_NONE, WIN_NONE, WIN1, WIN0})
  ) uut (
    .clk_pixel   (clk_pixel),
    .i_rst_n     (i_rst_n),
    .i_pixel_ena (i_pixel_ena),
    .o_pix       (o_pix),
    .o_hsync     (o_hsync),
    .o_vsync     (o_vsync),
    .o_blank     (o_blank)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic bit inside_window(input window_cfg_t w, input int x, input int y);
    return x >= int'(w.x_start) && x < int'(w.x_stop) &&
           y >= int'(w.y_start) && y < int'(w.y_stop);
  endfunction

  function automatic logic [23:0] window_rgb(input window_cfg_t w, input int x, input int y,
                                             input logic [23:0] below);
    if (!inside_window(w, x, y))
      return below;
    if (x < int'(w.x_start) + 2 || x >= int'(w.x_stop) - 2 ||
        y < int'(w.y_start) + 2 || y >= int'(w.y_stop) - 2)
      return w.border_color;
    return w.fill_color;
  endfunction

  // returns 0 for background, 1 for layer 0 only, 2 for overlap and 3 for layer 1 only
  function automatic int region_of(input int x, input int y);
    bit in0;
    bit in1;
    in0 = inside_window(WIN0, x, y);
    in1 = inside_window(WIN1, x, y);
    if (in0 && in1)
      return 2;
    if (in0)
      return 1;
    return in1 ? 3 : 0;
  endfunction

  function automatic int dither_chan(input int value, input int add, input int bits);
    int sum;
    sum = value + add;
    if (sum > 255)
      sum = 255;
    return sum >> (8 - bits);
  endfunction

  function automatic rgb565_t expected_pix(input int x, input int y);
    logic [23:0] rgb;
    int          d;
    rgb = {8'(x * 8), 8'(y * 16), 8'h40};
    rgb = window_rgb(WIN0, x, y, rgb);
    rgb = window_rgb(WIN1, x, y, rgb);
    // rows of the 2x2 matrix follow y parity
    if (y % 2 == 0)
      d = (x % 2 == 0) ? 0 : 2;
    else
      d = (x % 2 == 0) ? 3 : 1;
    return '{r: 5'(dither_chan(int'(rgb[23:16]), 2 * d, 5)),
             g: 6'(dither_chan(int'(rgb[15:8]), d, 6)),
             b: 5'(dither_chan(int'(rgb[7:0]), 2 * d, 5))};
  endfunction

  initial
  begin
    clk_pixel = 1'b0;
    forever #5 clk_pixel = ~clk_pixel;
  end

  always @(posedge clk_pixel)
  begin
    #1;
    if (rand_ena)
    begin
      lcg_state = lcg_next(lcg_state);
      i_pixel_ena = (lcg_state[31:30] != 2'b00);
    end
    else
    begin
      i_pixel_ena = 1'b1;
    end
  end

  assign hs_rise    = o_hsync && !hs_prev_m;
  assign vs_rise    = o_vsync && !vs_prev_m;
  assign pix_region = region_of(x_m, y_m);

  always_comb
  begin
    if (o_blank)
      exp_pix = '0;
    else
      exp_pix = expected_pix(x_m, y_m);
  end

  // the output pixel is consumed on each enabled edge as a next stage would do
  always @(posedge clk_pixel)
  begin
    if (!i_rst_n)
    begin
      x_m        <= 0;
      y_m        <= 0;
      hs_prev_m  <= 1'b0;
      vs_prev_m  <= 1'b0;
      line_act_m <= 1'b0;
      hs_cnt     <= 0;
      line_cnt   <= 0;
      pix_cnt    <= 0;
      frame_cnt  <= 0;
    end
    else if (i_pixel_ena)
    begin
      hs_prev_m <= o_hsync;
      vs_prev_m <= o_vsync;
      if (hs_rise)
      begin
        x_m        <= 0;
        line_act_m <= 1'b0;
        hs_cnt     <= hs_cnt + 1;
        if (line_act_m)
        begin
          y_m      <= y_m + 1;
          line_cnt <= line_cnt + 1;
        end
      end
      else if (!o_blank)
      begin
        x_m        <= x_m + 1;
        line_act_m <= 1'b1;
        pix_cnt    <= pix_cnt + 1;
      end
      if (o_vsync)
        y_m <= 0;
      if (vs_rise)
      begin
        frame_cnt   <= frame_cnt + 1;
        frame_hs    <= hs_cnt;
        frame_lines <= line_cnt;
        frame_pix   <= pix_cnt;
        hs_cnt      <= 0;
        line_cnt    <= 0;
        pix_cnt     <= 0;
      end
      if (phase == 2 && (o_blank || pix_region == 0))
        hit_bg <= hit_bg + 1;
      if (phase == 3 && !o_blank && pix_region == 1)
        hit_l0 <= hit_l0 + 1;
      if (phase == 4 && !o_blank && pix_region == 2)
        hit_ovl <= hit_ovl + 1;
      if (phase == 5)
        hit_frame <= hit_frame + 1;
    end
  end

  // checked at the falling edge where the outputs and the model are stable
  a_background: assert property (@(negedge clk_pixel) disable iff (!i_rst_n)
      (phase == 2 && i_pixel_ena && (o_blank || pix_region == 0)) |-> o_pix == exp_pix)
    else
    begin
      err_bg = err_bg + 1;
      $display("ERROR background: expected %h actual %h", exp_pix, o_pix);
    end

  a_single_window: assert property (@(negedge clk_pixel) disable iff (!i_rst_n)
      (phase == 3 && i_pixel_ena && !o_blank && pix_region == 1) |-> o_pix == exp_pix)
    else
    begin
      err_l0 = err_l0 + 1;
      $display("ERROR single_window: expected %h actual %h", exp_pix, o_pix);
    end

  a_priority: assert property (@(negedge clk_pixel) disable iff (!i_rst_n)
      (phase == 4 && i_pixel_ena && !o_blank && pix_region == 2) |-> o_pix == exp_pix)
    else
    begin
      err_ovl = err_ovl + 1;
      $display("ERROR priority: expected %h actual %h", exp_pix, o_pix);
    end

  a_enable_strobe: assert property (@(negedge clk_pixel) disable iff (!i_rst_n)
      (phase == 5 && i_pixel_ena) |-> o_pix == exp_pix)
    else
    begin
      err_frame = err_frame + 1;
      $display("ERROR enable_strobe: expected %h actual %h", exp_pix, o_pix);
    end

  // returns just after the edge that consumed the vsync rise, once the last check has run
  task automatic wait_frame(output bit ok);
    int start;
    int cycles;
    start  = frame_cnt;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < FRAME_TIMEOUT)
    begin
      @(posedge clk_pixel);
      #2;
      cycles++;
      if (frame_cnt != start)
        ok = 1'b1;
    end
    if (!ok)
      $display("timeout: no vsync on the output within %0d cycles", FRAME_TIMEOUT);
  endtask

  task automatic report_test(input string name, input int errors, input int checks);
    if (checks == 0)
    begin
      n_fail++;
      $display("%s: fail, no pixel of this kind was ever checked", name);
    end
    else if (errors == 0)
    begin
      n_pass++;
      $display("%s: pass, %0d checks", name, checks);
    end
    else
    begin
      n_fail++;
      $display("%s: fail, %0d errors in %0d checks", name, errors, checks);
    end
  endtask

  initial
  begin
    bit ok;
    i_rst_n     = 1'b0;
    i_pixel_ena = 1'b1;
    repeat (3) @(posedge clk_pixel);
    #1 i_rst_n = 1'b1;

    a_reset: assert (o_hsync == 1'b0 && o_vsync == 1'b0 && o_blank == 1'b1 && o_pix == '0)
      else
      begin
        err_reset++;
        $display("ERROR reset: expected hsync 0 vsync 0 blank 1 pix 0000 actual %b %b %b %h",
                 o_hsync, o_vsync, o_blank, o_pix);
      end
    report_test("reset", err_reset, 1);

    // align to the first frame boundary
    wait_frame(ok);
    if (ok)
    begin
      phase = 2;
      wait_frame(ok);
      report_test("background", err_bg, hit_bg);
    end
    if (ok)
    begin
      phase = 3;
      wait_frame(ok);
      report_test("single_window", err_l0, hit_l0);
    end
    if (ok)
    begin
      phase = 4;
      wait_frame(ok);
      report_test("priority", err_ovl, hit_ovl);
    end
    if (ok)
    begin
      phase    = 5;
      rand_ena = 1'b1;
      wait_frame(ok);
      rand_ena = 1'b0;
      phase    = 0;
      if (ok)
      begin
        a_hsync_count: assert (frame_hs == V_TOTAL)
          else
          begin
            err_count++;
            $display("ERROR enable_strobe: hsync pulses expected %0d actual %0d",
                     V_TOTAL, frame_hs);
          end
        a_line_count: assert (frame_lines == V_ACTIVE)
          else
          begin
            err_count++;
            $display("ERROR enable_strobe: active lines expected %0d actual %0d",
                     V_ACTIVE, frame_lines);
          end
        a_pixel_count: assert (frame_pix == H_ACTIVE * V_ACTIVE)
          else
          begin
            err_count++;
            $display("ERROR enable_strobe: active pixels expected %0d actual %0d",
                     H_ACTIVE * V_ACTIVE, frame_pix);
          end
      end
      report_test("enable_strobe", err_frame + err_count, hit_frame);
    end

    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (ok && n_fail == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* hdl/osd_top.sv */
// top level of the OSD subsystem: timing source, chain of window layers and 5-6-5 dither output
`timescale 1ns/1ns

module osd_top
  import osd_pkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33,
  parameter int N_LAYERS = 2,
  // element k configures layer k, unused entries are ignored
  parameter window_cfg_t [N_LAYERS_MAX-1:0] WINDOWS = '0
)
(
  input  logic    clk_pixel,
  input  logic    i_rst_n,
  input  logic    i_pixel_ena,
  output rgb565_t o_pix,
  output logic    o_hsync,
  output logic    o_vsync,
  output logic    o_blank
);

  // layer_bus[k] feeds layer k, the last entry feeds the dither stage
  video_pixel_t layer_bus [N_LAYERS+1];

  video_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_timing (
    .clk_pixel   (clk_pixel),
    .i_rst_n     (i_rst_n),
    .i_pixel_ena (i_pixel_ena),
    .o_pixel     (layer_bus[0])
  );

  // higher index layers sit later in the chain and win on overlap
  for (genvar k = 0; k < N_LAYERS; k++)
  begin : g_layer
    osd_window_layer #(
      .WINDOW (WINDOWS[k])
    ) u_layer (
      .clk_pixel   (clk_pixel),
      .i_rst_n     (i_rst_n),
      .i_pixel_ena (i_pixel_ena),
      .i_pixel     (layer_bus[k]),
      .o_pixel     (layer_bus[k+1])
    );
  end

  pixel_dither_565 u_dither (
    .clk_pixel   (clk_pixel),
    .i_rst_n     (i_rst_n),
    .i_pixel_ena (i_pixel_ena),
    .i_pixel     (layer_bus[N_LAYERS]),
    .o_pix       (o_pix),
    .o_hsync     (o_hsync),
    .o_vsync     (o_vsync),
    .o_blank     (o_blank)
  );

endmodule

/* hdl/pixel_dither_565.sv */
// output stage applying a 2x2 ordered dither and packing the stream to RGB 5-6-5
`timescale 1ns/1ns

module pixel_dither_565
  import osd_pkg::*;
(
  input  logic         clk_pixel,
  input  logic         i_rst_n,
  input  logic         i_pixel_ena,
  input  video_pixel_t i_pixel,
  output rgb565_t      o_pix,
  output logic         o_hsync,
  output logic         o_vsync,
  output logic         o_blank
);

  logic               hsync_prev;
  logic               hsync_rise;
  logic               line_active;
  logic               col_par;
  logic               row_par;
  logic [1:0]         bayer;
  logic [COLOR_W-1:0] r_sat;
  logic [COLOR_W-1:0] g_sat;
  logic [COLOR_W-1:0] b_sat;

  // add with clamp at full scale
  function automatic logic [COLOR_W-1:0] sat_add(input logic [COLOR_W-1:0] value,
                                                 input logic [2:0] offset);
    logic [COLOR_W:0] sum;
    sum = {1'b0, value} + (COLOR_W + 1)'(offset);
    return sum[COLOR_W] ? {COLOR_W{1'b1}} : sum[COLOR_W-1:0];
  endfunction

  assign hsync_rise = i_pixel.hsync & ~hsync_prev;

  always_comb
  begin
    // index is {row, column}
    case ({row_par, col_par})
      2'b00:   bayer = 2'd0;
      2'b01:   bayer = 2'd2;
      2'b10:   bayer = 2'd3;
      default: bayer = 2'd1;
    endcase
    r_sat = sat_add(i_pixel.r, {bayer, 1'b0});
    g_sat = sat_add(i_pixel.g, {1'b0, bayer});
    b_sat = sat_add(i_pixel.b, {bayer, 1'b0});
  end

  always_ff @(posedge clk_pixel)
  begin
    if (!i_rst_n)
    begin
      hsync_prev  <= 1'b0;
      line_active <= 1'b0;
      col_par     <= 1'b0;
      row_par     <= 1'b0;
      o_pix       <= '0;
      o_hsync     <= 1'b0;
      o_vsync     <= 1'b0;
      o_blank     <= 1'b1;
    end
    else if (i_pixel_ena)
    begin
      hsync_prev <= i_pixel.hsync;
      if (hsync_rise)
      begin
        col_par     <= 1'b0;
        line_active <= 1'b0;
        if (line_active)
          row_par <= ~row_par;
      end
      else if (!i_pixel.blank)
      begin
        col_par     <= ~col_par;
        line_active <= 1'b1;
      end
      if (i_pixel.vsync)
        row_par <= 1'b0;

      if (i_pixel.blank)
        o_pix <= '0;
      else
        o_pix <= '{r: r_sat[COLOR_W-1 -: R5_W], g: g_sat[COLOR_W-1 -: G6_W],
                   b: b_sat[COLOR_W-1 -: B5_W]};
      o_hsync <= i_pixel.hsync;
      o_vsync <= i_pixel.vsync;
      o_blank <= i_pixel.blank;
    end
  end

endmodule

/* hdl/osd_window_layer.sv */
// one OSD window layer that draws a bordered, filled rectangle over the incoming stream
`timescale 1ns/1ns

module osd_window_layer
  import osd_pkg::*;
#(
  parameter window_cfg_t WINDOW = '0
)
(
  input  logic         clk_pixel,
  input  logic         i_rst_n,
  input  logic         i_pixel_ena,
  input  video_pixel_t i_pixel,
  output video_pixel_t o_pixel
);

  // border thickness in pixels
  localparam int BORDER = 2;

  localparam logic [COORD_W-1:0] X_INNER_LO = WINDOW.x_start + COORD_W'(BORDER);
  localparam logic [COORD_W-1:0] X_INNER_HI = WINDOW.x_stop - COORD_W'(BORDER);
  localparam logic [COORD_W-1:0] Y_INNER_LO = WINDOW.y_start + COORD_W'(BORDER);
  localparam logic [COORD_W-1:0] Y_INNER_HI = WINDOW.y_stop - COORD_W'(BORDER);

  logic                 hsync_prev;
  logic                 hsync_rise;
  logic                 line_active;
  logic [COORD_W-1:0]   x_cnt;
  logic [COORD_W-1:0]   y_cnt;
  logic                 x_in;
  logic                 y_in;
  logic                 in_window;
  logic                 on_border;
  logic [3*COLOR_W-1:0] draw_rgb;

  assign hsync_rise = i_pixel.hsync & ~hsync_prev;

  // x counts unblanked pixels since hsync rise, y counts lines that had any
  always_ff @(posedge clk_pixel)
  begin
    if (!i_rst_n)
    begin
      hsync_prev  <= 1'b0;
      line_active <= 1'b0;
      x_cnt       <= '0;
      y_cnt       <= '0;
    end
    else if (i_pixel_ena)
    begin
      hsync_prev <= i_pixel.hsync;
      if (hsync_rise)
      begin
        x_cnt       <= '0;
        line_active <= 1'b0;
        if (line_active)
          y_cnt <= y_cnt + 1'b1;
      end
      else if (!i_pixel.blank)
      begin
        x_cnt       <= x_cnt + 1'b1;
        line_active <= 1'b1;
      end
      // vsync overrides any line increment
      if (i_pixel.vsync)
        y_cnt <= '0;
    end
  end

  always_comb
  begin
    x_in      = (x_cnt >= WINDOW.x_start) && (x_cnt < WINDOW.x_stop);
    y_in      = (y_cnt >= WINDOW.y_start) && (y_cnt < WINDOW.y_stop);
    in_window = ~i_pixel.blank & x_in & y_in;
    on_border = (x_cnt < X_INNER_LO) || (x_cnt >= X_INNER_HI) ||
                (y_cnt < Y_INNER_LO) || (y_cnt >= Y_INNER_HI);
    draw_rgb  = {i_pixel.r, i_pixel.g, i_pixel.b};
    if (in_window)
    begin
      if (on_border)
        draw_rgb = WINDOW.border_color;
      else
        draw_rgb = WINDOW.fill_color;
    end
  end

  // colour and syncs move together, one enabled cycle late
  always_ff @(posedge clk_pixel)
  begin
    if (!i_rst_n)
    begin
      o_pixel <= PIXEL_IDLE;
    end
    else if (i_pixel_ena)
    begin
      {o_pixel.r, o_pixel.g, o_pixel.b} <= draw_rgb;
      o_pixel.hsync <= i_pixel.hsync;
      o_pixel.vsync <= i_pixel.vsync;
      o_pixel.blank <= i_pixel.blank;
    end
  end

endmodule

/* hdl/video_timing.sv */
// raster timing generator producing syncs, blank and a coordinate test pattern for the OSD chain
`timescale 1ns/1ns

module video_timing
  import osd_pkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
)
(
  input  logic         clk_pixel,
  input  logic         i_rst_n,
  input  logic         i_pixel_ena,
  output video_pixel_t o_pixel
);

  // region boundaries, each one the first count of its region
  localparam logic [COORD_W-1:0] H_SYNC_START = COORD_W'(H_ACTIVE + H_FRONT);
  localparam logic [COORD_W-1:0] H_SYNC_END   = COORD_W'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam logic [COORD_W-1:0] H_LAST       = COORD_W'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
  localparam logic [COORD_W-1:0] V_SYNC_START = COORD_W'(V_ACTIVE + V_FRONT);
  localparam logic [COORD_W-1:0] V_SYNC_END   = COORD_W'(V_ACTIVE + V_FRONT + V_SYNC);
  localparam logic [COORD_W-1:0] V_LAST       = COORD_W'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
  localparam logic [COORD_W-1:0] H_ACT_END    = COORD_W'(H_ACTIVE);
  localparam logic [COORD_W-1:0] V_ACT_END    = COORD_W'(V_ACTIVE);

  logic [COORD_W-1:0] h_cnt;
  logic [COORD_W-1:0] v_cnt;
  logic               active;
  logic               hsync_on;
  logic               vsync_on;

  assign active   = (h_cnt < H_ACT_END) && (v_cnt < V_ACT_END);
  assign hsync_on = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
  assign vsync_on = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);

  always_ff @(posedge clk_pixel)
  begin
    if (!i_rst_n)
    begin
      h_cnt   <= '0;
      v_cnt   <= '0;
      o_pixel <= PIXEL_IDLE;
    end
    else if (i_pixel_ena)
    begin
      if (h_cnt == H_LAST)
      begin
        h_cnt <= '0;
        if (v_cnt == V_LAST)
          v_cnt <= '0;
        else
          v_cnt <= v_cnt + 1'b1;
      end
      else
      begin
        h_cnt <= h_cnt + 1'b1;
      end

      o_pixel.hsync <= hsync_on;
      o_pixel.vsync <= vsync_on;
      o_pixel.blank <= ~active;
      if (active)
      begin
        // r = x*8, g = y*16, both wrapping at 8 bits
        o_pixel.r <= COLOR_W'({h_cnt, 3'b000});
        o_pixel.g <= COLOR_W'({v_cnt, 4'b0000});
        o_pixel.b <= COLOR_W'(8'h40);
      end
      else
      begin
        o_pixel.r <= '0;
        o_pixel.g <= '0;
        o_pixel.b <= '0;
      end
    end
  end

endmodule

/* hdl/osd_pkg.sv */
// shared pixel, colour and window types for the OSD overlay pipeline, imported by every RTL block
package osd_pkg;

  // screen coordinate width, enough for 1023 pixels or lines
  localparam int COORD_W = 10;

  // bits per colour channel on the stream
  localparam int COLOR_W = 8;

  // channel widths of the packed 5-6-5 output
  localparam int R5_W = 5;
  localparam int G6_W = 6;
  localparam int B5_W = 5;

  // per-layer window arrays at the top are sized by this
  localparam int N_LAYERS_MAX = 4;

  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
    logic               hsync;
    logic               vsync;
    logic               blank;
  } video_pixel_t;

  typedef struct packed {
    logic [R5_W-1:0] r;
    logic [G6_W-1:0] g;
    logic [B5_W-1:0] b;
  } rgb565_t;

  // colours are {r, g, b} with red in the top byte
  typedef struct packed {
    logic [COORD_W-1:0]   x_start;
    logic [COORD_W-1:0]   x_stop;
    logic [COORD_W-1:0]   y_start;
    logic [COORD_W-1:0]   y_stop;
    logic [3*COLOR_W-1:0] border_color;
    logic [3*COLOR_W-1:0] fill_color;
  } window_cfg_t;

  // stream value held in reset and idle
  localparam video_pixel_t PIXEL_IDLE = '{r: '0, g: '0, b: '0, hsync: 1'b0, vsync: 1'b0,
                                          blank: 1'b1};

endpackage
